//--- dcache_config.svh
// --------------------
// size macros for the data cache miss handling path
// include in every module that sizes a port or a buffer
// --------------------

`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// address split and data word
`define DCACHE_TAG_W   8
`define DCACHE_IDX_W   4
`define DCACHE_WORD_W  32

// byte lanes of one word
`define DCACHE_SEL_W   (`DCACHE_WORD_W / 8)

// MSHR count must stay a power of two
`define MSHR_NUM       4
`define MSHR_IDX_W     2

// memory word address is tag over index
`define MEM_ADR_W      (`DCACHE_TAG_W + `DCACHE_IDX_W)

`endif

//--- dcache_pkg.sv
// --------------------
// shared types of the miss handling path
// import inside a module body, use scoped names in port lists
// --------------------

`default_nettype none

package dcache_pkg;

	// kind of miss held in an entry
	// MSG_NONE marks an empty slot
	typedef enum logic [1:0] {
		MSG_NONE  = 2'b00,
		MSG_LOAD  = 2'b01,
		MSG_STORE = 2'b10
	} message_t;

	// controller FSM
	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_BUS  = 1'b1
	} mshr_state_t;

endpackage : dcache_pkg

`default_nettype wire

//--- mshr_iss.sv
// --------------------
// MSHR issue queue
// misses are written at the tail and leave from the head in order
// the load queue probes all waiting entries by tag and index
// --------------------

`default_nettype none

`include "dcache_config.svh"

module mshr_iss (
	input  wire                         clk,
	input  wire                         rst,

	// allocation
	input  wire                         alloc_en_i,
	input  wire [`DCACHE_TAG_W-1:0]     alloc_tag_i,
	input  wire [`DCACHE_IDX_W-1:0]     alloc_idx_i,
	input  wire [`DCACHE_WORD_W-1:0]    alloc_data_i,
	input  wire dcache_pkg::message_t   alloc_message_i,

	// retire of the head entry
	input  wire                         ack_i,

	// load queue probe
	input  wire [`DCACHE_TAG_W-1:0]     lq_tag_i,
	input  wire [`DCACHE_IDX_W-1:0]     lq_idx_i,

	// head entry towards the bus master
	output logic                        head_vld_o,
	output logic [`DCACHE_TAG_W-1:0]    head_tag_o,
	output logic [`DCACHE_IDX_W-1:0]    head_idx_o,
	output logic [`DCACHE_WORD_W-1:0]   head_data_o,
	output dcache_pkg::message_t        head_message_o,
	output logic [`MSHR_IDX_W-1:0]      head_slot_o,

	// probe result
	output logic                        lq_hit_o,
	output logic [`DCACHE_WORD_W-1:0]   lq_hit_data_o,
	output dcache_pkg::message_t        lq_hit_message_o,

	output logic                        full_o
);

	import dcache_pkg::*;

	// entry storage
	logic [`MSHR_NUM-1:0]        vld_r;
	logic [`DCACHE_TAG_W-1:0]    tag_r     [`MSHR_NUM];
	logic [`DCACHE_IDX_W-1:0]    idx_r     [`MSHR_NUM];
	logic [`DCACHE_WORD_W-1:0]   data_r    [`MSHR_NUM];
	message_t                    message_r [`MSHR_NUM];

	// pointers, top bit is the wrap bit
	logic [`MSHR_IDX_W:0]        head_ptr_r;
	logic [`MSHR_IDX_W:0]        tail_ptr_r;
	logic [`MSHR_IDX_W-1:0]      head_slot;
	logic [`MSHR_IDX_W-1:0]      tail_slot;
	logic                        same_slot;
	logic                        same_wrap;

	// slot visited by the probe scan
	logic [`MSHR_IDX_W-1:0]      probe_slot;

	assign head_slot = head_ptr_r[`MSHR_IDX_W-1:0];
	assign tail_slot = tail_ptr_r[`MSHR_IDX_W-1:0];
	assign same_slot = (head_slot == tail_slot);
	assign same_wrap = (head_ptr_r[`MSHR_IDX_W] == tail_ptr_r[`MSHR_IDX_W]);

	// same slot on different laps
	assign full_o = same_slot && !same_wrap;

	// --------------------
	// head entry
	// --------------------
	assign head_vld_o     = vld_r[head_slot];
	assign head_tag_o     = tag_r[head_slot];
	assign head_idx_o     = idx_r[head_slot];
	assign head_data_o    = data_r[head_slot];
	assign head_message_o = vld_r[head_slot] ? message_r[head_slot] : MSG_NONE;
	assign head_slot_o    = head_slot;

	// --------------------
	// probe
	// --------------------
	// walk from head towards tail so the youngest match is written last
	always_comb begin
		lq_hit_o         = 1'b0;
		lq_hit_data_o    = '0;
		lq_hit_message_o = MSG_NONE;
		probe_slot       = head_slot;
		for (int k = 0; k < `MSHR_NUM; k++) begin
			probe_slot = head_slot + `MSHR_IDX_W'(k);
			if (vld_r[probe_slot] && (tag_r[probe_slot] == lq_tag_i) &&
					(idx_r[probe_slot] == lq_idx_i)) begin
				lq_hit_o         = 1'b1;
				lq_hit_data_o    = data_r[probe_slot];
				lq_hit_message_o = message_r[probe_slot];
			end
		end
	end

	// --------------------
	// pointers and valid bits
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			head_ptr_r <= '0;
			tail_ptr_r <= '0;
		end else begin
			if (alloc_en_i) begin
				tail_ptr_r <= tail_ptr_r + 1'b1;
			end
			if (ack_i) begin
				head_ptr_r <= head_ptr_r + 1'b1;
			end
		end
	end

	// alloc and ack never hit the same slot, the queue is not full on alloc
	always_ff @(posedge clk) begin
		if (rst) begin
			vld_r <= '0;
		end else begin
			if (alloc_en_i) begin
				vld_r[tail_slot] <= 1'b1;
			end
			if (ack_i) begin
				vld_r[head_slot] <= 1'b0;
			end
		end
	end

	// entry payload
	always_ff @(posedge clk) begin
		if (alloc_en_i) begin
			tag_r[tail_slot]     <= alloc_tag_i;
			idx_r[tail_slot]     <= alloc_idx_i;
			data_r[tail_slot]    <= alloc_data_i;
			message_r[tail_slot] <= alloc_message_i;
		end
	end

	// --------------------
	// checks
	// --------------------
	// the controller must hold off allocation while every slot is taken
	assert property (@(posedge clk) disable iff (rst) alloc_en_i |-> !full_o)
		else $error("mshr_iss: allocation into a full queue");

	// retire only ever follows a transfer of a live head entry
	assert property (@(posedge clk) disable iff (rst) ack_i |-> vld_r[head_slot])
		else $error("mshr_iss: ack with an empty head entry");

endmodule : mshr_iss

`default_nettype wire

//--- mshr_ctrl.sv
// --------------------
// MSHR controller
// grants allocation, starts one bus transfer at a time
// and retires the head entry when the transfer completes
// --------------------

`default_nettype none

module mshr_ctrl (
	input  wire   clk,
	input  wire   rst,

	// cache request handshake
	input  wire   req_valid_i,
	output logic  req_ready_o,

	// queue status
	input  wire   full_i,
	input  wire   head_vld_i,

	// bus master status
	input  wire   bus_done_i,

	// controls
	output logic  alloc_en_o,
	output logic  issue_start_o,
	output logic  ack_pop_o
);

	import dcache_pkg::*;

	mshr_state_t  state_r;
	mshr_state_t  state_nxt;

	// --------------------
	// allocation
	// --------------------
	// ready only depends on free slots
	assign req_ready_o = !full_i;
	assign alloc_en_o  = req_valid_i && !full_i;

	// --------------------
	// FSM
	// --------------------
	assign issue_start_o = (state_r == ST_IDLE) && head_vld_i;
	assign ack_pop_o     = (state_r == ST_BUS) && bus_done_i;

	always_comb begin
		state_nxt = state_r;
		case (state_r)
			ST_IDLE: begin
				if (issue_start_o) begin
					state_nxt = ST_BUS;
				end
			end
			ST_BUS: begin
				// back to idle on the ack edge
				if (bus_done_i) begin
					state_nxt = ST_IDLE;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_r <= ST_IDLE;
		end else begin
			state_r <= state_nxt;
		end
	end

	// --------------------
	// checks
	// --------------------
	// the master only reports completion of a transfer this FSM started
	assert property (@(posedge clk) disable iff (rst) bus_done_i |-> (state_r == ST_BUS))
		else $error("mshr_ctrl: bus completion outside of a transfer");

endmodule : mshr_ctrl

`default_nettype wire

//--- mem_wb_master.sv
// --------------------
// Wishbone classic master for the MSHR queue
// holds one transfer on the bus until ack
// and turns the ack into a one cycle response
// --------------------

`default_nettype none

`include "dcache_config.svh"

module mem_wb_master (
	input  wire                          clk,
	input  wire                          rst,

	// transfer request from the head entry
	input  wire                          issue_start_i,
	input  wire [`DCACHE_TAG_W-1:0]      head_tag_i,
	input  wire [`DCACHE_IDX_W-1:0]      head_idx_i,
	input  wire [`DCACHE_WORD_W-1:0]     head_data_i,
	input  wire dcache_pkg::message_t    head_message_i,
	input  wire [`MSHR_IDX_W-1:0]        head_slot_i,

	// Wishbone
	output logic                         wb_cyc_o,
	output logic                         wb_stb_o,
	output logic                         wb_we_o,
	output logic [`MEM_ADR_W-1:0]        wb_adr_o,
	output logic [`DCACHE_WORD_W-1:0]    wb_dat_o,
	output logic [`DCACHE_SEL_W-1:0]     wb_sel_o,
	input  wire  [`DCACHE_WORD_W-1:0]    wb_dat_i,
	input  wire                          wb_ack_i,

	output logic                         bus_done_o,

	// response to the cache
	output logic                         resp_valid_o,
	output logic [`DCACHE_WORD_W-1:0]    resp_data_o,
	output dcache_pkg::message_t         resp_message_o,
	output logic [`MSHR_IDX_W-1:0]       resp_slot_o
);

	import dcache_pkg::*;

	// transfer in flight
	logic                        cyc_r;
	logic                        stb_r;
	logic                        we_r;
	logic [`MEM_ADR_W-1:0]       adr_r;
	logic [`DCACHE_WORD_W-1:0]   dat_r;
	message_t                    msg_r;
	logic [`MSHR_IDX_W-1:0]      slot_r;

	// ack only counts inside an open cycle
	assign bus_done_o = cyc_r && wb_ack_i;

	assign wb_cyc_o = cyc_r;
	assign wb_stb_o = stb_r;
	assign wb_we_o  = we_r;
	assign wb_adr_o = adr_r;
	assign wb_dat_o = dat_r;
	assign wb_sel_o = '1;

	// --------------------
	// bus control
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			cyc_r <= 1'b0;
			stb_r <= 1'b0;
			we_r  <= 1'b0;
		end else if (issue_start_i) begin
			cyc_r <= 1'b1;
			stb_r <= 1'b1;
			we_r  <= (head_message_i == MSG_STORE);
		end else if (bus_done_o) begin
			cyc_r <= 1'b0;
			stb_r <= 1'b0;
			we_r  <= 1'b0;
		end
	end

	// address is tag over index
	always_ff @(posedge clk) begin
		if (issue_start_i) begin
			adr_r  <= {head_tag_i, head_idx_i};
			dat_r  <= head_data_i;
			msg_r  <= head_message_i;
			slot_r <= head_slot_i;
		end
	end

	// --------------------
	// response
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			resp_valid_o <= 1'b0;
		end else begin
			resp_valid_o <= bus_done_o;
		end
	end

	// stores read back zero from the slave
	always_ff @(posedge clk) begin
		if (bus_done_o) begin
			resp_data_o    <= wb_dat_i;
			resp_message_o <= msg_r;
			resp_slot_o    <= slot_r;
		end
	end

	// --------------------
	// checks
	// --------------------
	// a new transfer only starts once the previous cycle has closed
	assert property (@(posedge clk) disable iff (rst) issue_start_i |-> !cyc_r)
		else $error("mem_wb_master: transfer started over an open cycle");

endmodule : mem_wb_master

`default_nettype wire

//--- dcache_mshr.sv
// --------------------
// top of the data cache miss handling path
// cache request and response ports, load queue probe
// and a Wishbone classic master towards memory
// --------------------

`default_nettype none

`include "dcache_config.svh"

module dcache_mshr (
	input  wire                          clk,
	input  wire                          rst,

	// miss requests from the cache
	input  wire                          req_valid_i,
	output logic                         req_ready_o,
	input  wire [`DCACHE_TAG_W-1:0]      req_tag_i,
	input  wire [`DCACHE_IDX_W-1:0]      req_idx_i,
	input  wire [`DCACHE_WORD_W-1:0]     req_data_i,
	input  wire dcache_pkg::message_t    req_message_i,

	// load queue probe
	input  wire [`DCACHE_TAG_W-1:0]      lq_tag_i,
	input  wire [`DCACHE_IDX_W-1:0]      lq_idx_i,
	output logic                         lq_hit_o,
	output logic [`DCACHE_WORD_W-1:0]    lq_hit_data_o,
	output dcache_pkg::message_t         lq_hit_message_o,

	// responses back to the cache
	output logic                         resp_valid_o,
	output logic [`DCACHE_WORD_W-1:0]    resp_data_o,
	output dcache_pkg::message_t         resp_message_o,
	output logic [`MSHR_IDX_W-1:0]       resp_slot_o,

	// Wishbone classic master
	output logic                         wb_cyc_o,
	output logic                         wb_stb_o,
	output logic                         wb_we_o,
	output logic [`MEM_ADR_W-1:0]        wb_adr_o,
	output logic [`DCACHE_WORD_W-1:0]    wb_dat_o,
	output logic [`DCACHE_SEL_W-1:0]     wb_sel_o,
	input  wire  [`DCACHE_WORD_W-1:0]    wb_dat_i,
	input  wire                          wb_ack_i
);

	import dcache_pkg::*;

	// controller outputs
	logic                        alloc_en;
	logic                        issue_start;
	logic                        ack_pop;

	// queue status and head entry
	logic                        full;
	logic                        head_vld;
	logic [`DCACHE_TAG_W-1:0]    head_tag;
	logic [`DCACHE_IDX_W-1:0]    head_idx;
	logic [`DCACHE_WORD_W-1:0]   head_data;
	message_t                    head_message;
	logic [`MSHR_IDX_W-1:0]      head_slot;

	logic                        bus_done;

	mshr_ctrl i_mshr_ctrl (
		.clk           (clk),
		.rst           (rst),
		.req_valid_i   (req_valid_i),
		.req_ready_o   (req_ready_o),
		.full_i        (full),
		.head_vld_i    (head_vld),
		.bus_done_i    (bus_done),
		.alloc_en_o    (alloc_en),
		.issue_start_o (issue_start),
		.ack_pop_o     (ack_pop)
	);

	mshr_iss i_mshr_iss (
		.clk              (clk),
		.rst              (rst),
		.alloc_en_i       (alloc_en),
		.alloc_tag_i      (req_tag_i),
		.alloc_idx_i      (req_idx_i),
		.alloc_data_i     (req_data_i),
		.alloc_message_i  (req_message_i),
		.ack_i            (ack_pop),
		.lq_tag_i         (lq_tag_i),
		.lq_idx_i         (lq_idx_i),
		.head_vld_o       (head_vld),
		.head_tag_o       (head_tag),
		.head_idx_o       (head_idx),
		.head_data_o      (head_data),
		.head_message_o   (head_message),
		.head_slot_o      (head_slot),
		.lq_hit_o         (lq_hit_o),
		.lq_hit_data_o    (lq_hit_data_o),
		.lq_hit_message_o (lq_hit_message_o),
		.full_o           (full)
	);

	mem_wb_master i_mem_wb_master (
		.clk            (clk),
		.rst            (rst),
		.issue_start_i  (issue_start),
		.head_tag_i     (head_tag),
		.head_idx_i     (head_idx),
		.head_data_i    (head_data),
		.head_message_i (head_message),
		.head_slot_i    (head_slot),
		.wb_cyc_o       (wb_cyc_o),
		.wb_stb_o       (wb_stb_o),
		.wb_we_o        (wb_we_o),
		.wb_adr_o       (wb_adr_o),
		.wb_dat_o       (wb_dat_o),
		.wb_sel_o       (wb_sel_o),
		.wb_dat_i       (wb_dat_i),
		.wb_ack_i       (wb_ack_i),
		.bus_done_o     (bus_done),
		.resp_valid_o   (resp_valid_o),
		.resp_data_o    (resp_data_o),
		.resp_message_o (resp_message_o),
		.resp_slot_o    (resp_slot_o)
	);

endmodule : dcache_mshr

`default_nettype wire

//--- tb_dcache_mshr.sv
// --------------------
// testbench for the MSHR miss path
// runs a stimulus table against dcache_mshr with a Wishbone memory model
// and checks probes, bus transfers and responses against a scoreboard
// --------------------

`default_nettype none

`include "dcache_config.svh"

module tb_dcache_mshr;

	import dcache_pkg::*;

	typedef enum {OP_REQ, OP_PROBE, OP_HOLD, OP_FULL, OP_DRAIN} op_t;

	localparam int MAX_ROWS = 64;
	localparam int RAND_REQS = 24;

	logic                        clk;
	logic                        rst;
	logic                        req_valid_i;
	logic                        req_ready_o;
	logic [`DCACHE_TAG_W-1:0]    req_tag_i;
	logic [`DCACHE_IDX_W-1:0]    req_idx_i;
	logic [`DCACHE_WORD_W-1:0]   req_data_i;
	message_t                    req_message_i;
	logic [`DCACHE_TAG_W-1:0]    lq_tag_i;
	logic [`DCACHE_IDX_W-1:0]    lq_idx_i;
	logic                        lq_hit_o;
	logic [`DCACHE_WORD_W-1:0]   lq_hit_data_o;
	message_t                    lq_hit_message_o;
	logic                        resp_valid_o;
	logic [`DCACHE_WORD_W-1:0]   resp_data_o;
	message_t                    resp_message_o;
	logic [`MSHR_IDX_W-1:0]      resp_slot_o;
	logic                        wb_cyc_o;
	logic                        wb_stb_o;
	logic                        wb_we_o;
	logic [`MEM_ADR_W-1:0]       wb_adr_o;
	logic [`DCACHE_WORD_W-1:0]   wb_dat_o;
	logic [`DCACHE_SEL_W-1:0]    wb_sel_o;
	logic [`DCACHE_WORD_W-1:0]   wb_dat_i;
	logic                        wb_ack_i;

	// stimulus table
	op_t                         op_tab       [MAX_ROWS];
	logic [`DCACHE_TAG_W-1:0]    tag_tab      [MAX_ROWS];
	logic [`DCACHE_IDX_W-1:0]    idx_tab      [MAX_ROWS];
	logic [`DCACHE_WORD_W-1:0]   data_tab     [MAX_ROWS];
	message_t                    msg_tab      [MAX_ROWS];
	logic                        exp_hit_tab  [MAX_ROWS];
	logic [`DCACHE_WORD_W-1:0]   exp_data_tab [MAX_ROWS];
	message_t                    exp_msg_tab  [MAX_ROWS];
	int                          n_rows = 0;

	// scoreboard of accepted requests, oldest first
	logic [`DCACHE_TAG_W-1:0]    sb_tag  [$];
	logic [`DCACHE_IDX_W-1:0]    sb_idx  [$];
	logic [`DCACHE_WORD_W-1:0]   sb_data [$];
	message_t                    sb_msg  [$];
	logic [`MSHR_IDX_W-1:0]      sb_slot [$];
	int                          accepted_count = 0;

	// memory model state
	integer                      seed = 32'hc14e_c6e2;
	logic                        hold_ack;
	logic                        started;
	int                          ack_wait;
	int                          ack_count = 0;

	int                          cycle_count = 0;
	int                          cycle_limit = 100;

	dcache_mshr i_dcache_mshr (
		.clk              (clk),
		.rst              (rst),
		.req_valid_i      (req_valid_i),
		.req_ready_o      (req_ready_o),
		.req_tag_i        (req_tag_i),
		.req_idx_i        (req_idx_i),
		.req_data_i       (req_data_i),
		.req_message_i    (req_message_i),
		.lq_tag_i         (lq_tag_i),
		.lq_idx_i         (lq_idx_i),
		.lq_hit_o         (lq_hit_o),
		.lq_hit_data_o    (lq_hit_data_o),
		.lq_hit_message_o (lq_hit_message_o),
		.resp_valid_o     (resp_valid_o),
		.resp_data_o      (resp_data_o),
		.resp_message_o   (resp_message_o),
		.resp_slot_o      (resp_slot_o),
		.wb_cyc_o         (wb_cyc_o),
		.wb_stb_o         (wb_stb_o),
		.wb_we_o          (wb_we_o),
		.wb_adr_o         (wb_adr_o),
		.wb_dat_o         (wb_dat_o),
		.wb_sel_o         (wb_sel_o),
		.wb_dat_i         (wb_dat_i),
		.wb_ack_i         (wb_ack_i)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// --------------------
	// reporting and checks
	// --------------------
	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [`DCACHE_WORD_W-1:0] got,
			input logic [`DCACHE_WORD_W-1:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_msg(input string name, input message_t got, input message_t exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("Mismatch at %0t: %s got %s (%b) expected %s (%b)",
				$time, name, got.name(), got, exp.name(), exp));
		end
	endtask

	task automatic check_slot(input string name, input logic [`MSHR_IDX_W-1:0] got,
			input logic [`MSHR_IDX_W-1:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("Mismatch at %0t: %s got %0d expected %0d",
				$time, name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("Mismatch at %0t: %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	// load word: address in the lower half, its inverse above
	function automatic logic [`DCACHE_WORD_W-1:0] mem_word(input logic [`MEM_ADR_W-1:0] adr);
		logic [`DCACHE_WORD_W/2-1:0] low;
		low = (`DCACHE_WORD_W/2)'(adr);
		return {~low, low};
	endfunction

	// --------------------
	// memory model and monitor
	// --------------------
	// bus fields of the transfer being acked against the oldest request
	task automatic check_transfer();
		if (sb_slot.size() == 0) begin
			stop_with_failure("bus transfer seen with no outstanding request");
		end
		check_word("wb_adr_o", wb_adr_o, {sb_tag[0], sb_idx[0]});
		check_bit("wb_we_o", wb_we_o, sb_msg[0] == MSG_STORE);
		check_word("wb_sel_o", wb_sel_o, {`DCACHE_SEL_W{1'b1}});
		if (sb_msg[0] == MSG_STORE) begin
			check_word("wb_dat_o", wb_dat_o, sb_data[0]);
		end
	endtask

	task automatic check_response();
		logic [`DCACHE_WORD_W-1:0] exp_data;
		if (sb_slot.size() == 0) begin
			stop_with_failure("response seen with no outstanding request");
		end
		exp_data = (sb_msg[0] == MSG_STORE) ? '0 : mem_word({sb_tag[0], sb_idx[0]});
		check_slot("resp_slot_o", resp_slot_o, sb_slot[0]);
		check_msg("resp_message_o", resp_message_o, sb_msg[0]);
		check_word("resp_data_o", resp_data_o, exp_data);
		void'(sb_tag.pop_front());
		void'(sb_idx.pop_front());
		void'(sb_data.pop_front());
		void'(sb_msg.pop_front());
		void'(sb_slot.pop_front());
	endtask

	// slave acks 0 to 3 cycles after stb, responses follow each ack
	always @(negedge clk) begin
		if (rst) begin
			wb_ack_i = 1'b0;
			started  = 1'b0;
			ack_wait = 0;
		end else begin
			check_bit("wb_stb_o", wb_stb_o, wb_cyc_o);
			check_bit("resp_valid_o", resp_valid_o, wb_ack_i);
			if (resp_valid_o) begin
				check_response();
			end
			if (wb_ack_i) begin
				wb_ack_i = 1'b0;
			end else if (wb_cyc_o && wb_stb_o && !hold_ack) begin
				if (!started) begin
					ack_wait = $unsigned($random(seed)) % 4;
					started  = 1'b1;
				end
				if (ack_wait == 0) begin
					check_transfer();
					wb_dat_i  = wb_we_o ? '0 : mem_word(wb_adr_o);
					wb_ack_i  = 1'b1;
					started   = 1'b0;
					ack_count = ack_count + 1;
				end else begin
					ack_wait = ack_wait - 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			stop_with_failure("timeout: the stimulus table did not complete in time");
		end
	end

	// --------------------
	// table
	// --------------------
	task automatic add_row(input op_t op, input logic [`DCACHE_TAG_W-1:0] tag,
			input logic [`DCACHE_IDX_W-1:0] idx, input logic [`DCACHE_WORD_W-1:0] data,
			input message_t msg, input logic hit, input logic [`DCACHE_WORD_W-1:0] hit_data,
			input message_t hit_msg);
		op_tab[n_rows]       = op;
		tag_tab[n_rows]      = tag;
		idx_tab[n_rows]      = idx;
		data_tab[n_rows]     = data;
		msg_tab[n_rows]      = msg;
		exp_hit_tab[n_rows]  = hit;
		exp_data_tab[n_rows] = hit_data;
		exp_msg_tab[n_rows]  = hit_msg;
		n_rows = n_rows + 1;
	endtask

	task automatic build_table();
		message_t msg;
		// fill the queue with acks held, probe it, then overflow by one
		add_row(OP_HOLD,  8'h00, 4'h0, 32'h0, MSG_NONE, 1'b0, 32'h0, MSG_NONE);
		add_row(OP_REQ,   8'h12, 4'h3, 32'h5a5a_0001, MSG_LOAD, 1'b0, 32'h0, MSG_NONE);
		add_row(OP_PROBE, 8'h12, 4'h3, 32'h0, MSG_NONE, 1'b1, 32'h5a5a_0001, MSG_LOAD);
		add_row(OP_REQ,   8'h12, 4'h3, 32'hdead_beef, MSG_STORE, 1'b0, 32'h0, MSG_NONE);
		add_row(OP_PROBE, 8'h12, 4'h3, 32'h0, MSG_NONE, 1'b1, 32'hdead_beef, MSG_STORE);
		add_row(OP_REQ,   8'h40, 4'h7, 32'h1111_2222, MSG_STORE, 1'b0, 32'h0, MSG_NONE);
		add_row(OP_PROBE, 8'h40, 4'h8, 32'h0, MSG_NONE, 1'b0, 32'h0, MSG_NONE);
		add_row(OP_REQ,   8'ha5, 4'hf, 32'h0bad_0003, MSG_LOAD, 1'b0, 32'h0, MSG_NONE);
		add_row(OP_PROBE, 8'ha5, 4'hf, 32'h0, MSG_NONE, 1'b1, 32'h0bad_0003, MSG_LOAD);
		add_row(OP_FULL,  8'h77, 4'h1, 32'hcafe_f00d, MSG_STORE, 1'b0, 32'h0, MSG_NONE);
		add_row(OP_DRAIN, 8'h00, 4'h0, 32'h0, MSG_NONE, 1'b0, 32'h0, MSG_NONE);
		add_row(OP_PROBE, 8'h12, 4'h3, 32'h0, MSG_NONE, 1'b0, 32'h0, MSG_NONE);
		add_row(OP_PROBE, 8'h77, 4'h1, 32'h0, MSG_NONE, 1'b0, 32'h0, MSG_NONE);
		// random mixed stream at random latency
		for (int i = 0; i < RAND_REQS; i++) begin
			msg = ($random(seed) & 1) ? MSG_STORE : MSG_LOAD;
			add_row(OP_REQ, $random(seed), $random(seed), $random(seed), msg,
				1'b0, 32'h0, MSG_NONE);
		end
		add_row(OP_DRAIN, 8'h00, 4'h0, 32'h0, MSG_NONE, 1'b0, 32'h0, MSG_NONE);
		add_row(OP_PROBE, 8'ha5, 4'hf, 32'h0, MSG_NONE, 1'b0, 32'h0, MSG_NONE);
	endtask

	// every request row of the table ends in exactly one bus transfer
	function automatic int count_request_rows();
		int n;
		n = 0;
		for (int r = 0; r < n_rows; r++) begin
			if (op_tab[r] == OP_REQ || op_tab[r] == OP_FULL) begin
				n = n + 1;
			end
		end
		return n;
	endfunction

	// --------------------
	// row actions
	// --------------------
	task automatic record_request(input int r);
		sb_tag.push_back(tag_tab[r]);
		sb_idx.push_back(idx_tab[r]);
		sb_data.push_back(data_tab[r]);
		sb_msg.push_back(msg_tab[r]);
		sb_slot.push_back(`MSHR_IDX_W'(accepted_count));
		accepted_count = accepted_count + 1;
	endtask

	// hold the request until ready, accepted on the next rising edge
	task automatic send_request(input int r);
		req_valid_i   = 1'b1;
		req_tag_i     = tag_tab[r];
		req_idx_i     = idx_tab[r];
		req_data_i    = data_tab[r];
		req_message_i = msg_tab[r];
		while (!req_ready_o) begin
			@(negedge clk);
		end
		record_request(r);
		@(negedge clk);
		req_valid_i = 1'b0;
	endtask

	task automatic run_probe(input int r);
		lq_tag_i = tag_tab[r];
		lq_idx_i = idx_tab[r];
		#1;
		check_bit("lq_hit_o", lq_hit_o, exp_hit_tab[r]);
		if (exp_hit_tab[r]) begin
			check_word("lq_hit_data_o", lq_hit_data_o, exp_data_tab[r]);
			check_msg("lq_hit_message_o", lq_hit_message_o, exp_msg_tab[r]);
		end
		@(negedge clk);
	endtask

	// request into a full queue waits for a completion
	task automatic check_back_pressure(input int r);
		int acks_before;
		req_valid_i   = 1'b1;
		req_tag_i     = tag_tab[r];
		req_idx_i     = idx_tab[r];
		req_data_i    = data_tab[r];
		req_message_i = msg_tab[r];
		for (int i = 0; i < 4; i++) begin
			check_bit("req_ready_o", req_ready_o, 1'b0);
			@(negedge clk);
		end
		acks_before = ack_count;
		hold_ack = 1'b0;
		send_request(r);
		if (ack_count == acks_before) begin
			stop_with_failure("request into a full queue was accepted before any ack");
		end
	endtask

	task automatic apply_row(input int r);
		case (op_tab[r])
			OP_REQ:   send_request(r);
			OP_PROBE: run_probe(r);
			OP_FULL:  check_back_pressure(r);
			OP_HOLD: begin
				hold_ack = 1'b1;
				@(negedge clk);
			end
			OP_DRAIN: begin
				hold_ack = 1'b0;
				while (sb_slot.size() != 0) begin
					@(negedge clk);
				end
				@(negedge clk);
			end
			default: stop_with_failure("unknown operation in the stimulus table");
		endcase
	endtask

	task automatic check_reset_state();
		check_bit("req_ready_o", req_ready_o, 1'b1);
		check_bit("wb_cyc_o", wb_cyc_o, 1'b0);
		check_bit("wb_stb_o", wb_stb_o, 1'b0);
		check_bit("wb_we_o", wb_we_o, 1'b0);
		check_bit("resp_valid_o", resp_valid_o, 1'b0);
		check_bit("lq_hit_o", lq_hit_o, 1'b0);
	endtask

	initial begin
		rst           = 1'b1;
		req_valid_i   = 1'b0;
		req_tag_i     = '0;
		req_idx_i     = '0;
		req_data_i    = '0;
		req_message_i = MSG_NONE;
		lq_tag_i      = '0;
		lq_idx_i      = '0;
		wb_dat_i      = '0;
		wb_ack_i      = 1'b0;
		hold_ack      = 1'b0;
		build_table();
		cycle_limit = 20 * n_rows + 100;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_reset_state();
		for (int r = 0; r < n_rows; r++) begin
			apply_row(r);
		end
		if (ack_count != count_request_rows()) begin
			stop_with_failure($sformatf("Mismatch at %0t: ack_count got %0d expected %0d",
				$time, ack_count, count_request_rows()));
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule : tb_dcache_mshr

`default_nettype wire

//--- list.f
+incdir+.
dcache_pkg.sv
mshr_iss.sv
mshr_ctrl.sv
mem_wb_master.sv
dcache_mshr.sv
tb_dcache_mshr.sv
